// File: sources.f
hdl/openadc_regs_pkg.sv
hdl/host_link_pkg.sv
hdl/host_cmd_seq.sv
hdl/config_regs.sv
hdl/usb_interface.sv
bench/tb_usb_interface.sv

// File: Makefile
TOP = tb_usb_interface

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f sources.f \
		--top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee /dev/stderr | grep "^Everything OK$$" > /dev/null

lint:
	verilator --lint-only --timing -Wall -f sources.f --top-module $(TOP)
	verilator --lint-only -Wall hdl/openadc_regs_pkg.sv hdl/host_link_pkg.sv \
		hdl/host_cmd_seq.sv hdl/config_regs.sv hdl/usb_interface.sv \
		--top-module usb_interface

clean:
	rm -rf obj_dir

// File: bench/tb_usb_interface.sv
`timescale 1ns/1ps
`default_nettype none

module tb_usb_interface;

	localparam int MAX_CYCLES = 20000;

	logic                         ftdi_clk;
	logic                         reset_i;
	host_link_pkg::host_in_t      host_in;
	host_link_pkg::host_out_t     host_out;
	openadc_regs_pkg::byte_t      status;
	logic                         fifo_empty;
	openadc_regs_pkg::byte_t      fifo_data;
	logic                         fifo_rd_en;
	openadc_regs_pkg::word_t      extclk_freq;
	openadc_regs_pkg::phase_t     phase_in;
	logic                         phase_done;
	openadc_regs_pkg::word_t      maxsamples_in;
	logic                         reset_out;
	logic                         hilow;
	logic                         adc_clk_src;
	logic                         phase_ld;
	openadc_regs_pkg::byte_t      gain;
	openadc_regs_pkg::trig_ctrl_t trig;
	openadc_regs_pkg::word_t      maxsamples_out;
	openadc_regs_pkg::phase_t     phase_out;

	openadc_regs_pkg::byte_t fifo_q[$];
	logic                    random_txe;
	int                      cycles;
	int                      wr_count;
	int                      ld_count;
	int                      rst_count;
	int                      err_count;
	int                      test_errs;
	int                      tests_run;
	openadc_regs_pkg::word_t exp_offset;

	usb_interface UUT (
		.ftdi_clk           (ftdi_clk),
		.reset_i            (reset_i),
		.host_i             (host_in),
		.host_o             (host_out),
		.status_i           (status),
		.fifo_empty_i       (fifo_empty),
		.fifo_data_i        (fifo_data),
		.fifo_rd_en_o       (fifo_rd_en),
		.extclk_frequency_i (extclk_freq),
		.phase_i            (phase_in),
		.phase_done_i       (phase_done),
		.maxsamples_i       (maxsamples_in),
		.reset_o            (reset_out),
		.hilow_o            (hilow),
		.adc_clk_src_o      (adc_clk_src),
		.phase_ld_o         (phase_ld),
		.gain_o             (gain),
		.trig_o             (trig),
		.maxsamples_o       (maxsamples_out),
		.phase_o            (phase_out)
	);

	initial begin
		ftdi_clk = 1'b0;
		forever #20 ftdi_clk = ~ftdi_clk;
	end

	// Run limit, twice the worst case of all tests
	always @(posedge ftdi_clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Run stopped after %0d cycles without finishing the tests", cycles);
			$display("Something failed");
			$finish;
		end
	end

	// Host room, random only during the stream test
	always @(posedge ftdi_clk) begin
		if (random_txe)
			host_in.txe <= 1'($urandom_range(0, 1));
		else
			host_in.txe <= 1'b1;
	end

	// First-word-fall-through sample FIFO
	always @(posedge ftdi_clk) begin
		if (fifo_rd_en && fifo_q.size() > 0)
			void'(fifo_q.pop_front());
		fifo_empty <= (fifo_q.size() == 0);
		fifo_data  <= (fifo_q.size() > 0) ? fifo_q[0] : 8'h00;
	end

	// Event counters, sampled mid cycle
	always @(negedge ftdi_clk) begin
		if (host_out.wr)
			wr_count <= wr_count + 1;
		if (phase_ld)
			ld_count <= ld_count + 1;
		if (reset_out && !reset_i)
			rst_count <= rst_count + 1;
	end

	task automatic report_error(input string msg);
		$display("mismatch at %0d ns: %s", $time, msg);
		test_errs++;
	endtask

	task automatic check_byte(input string what, input openadc_regs_pkg::byte_t got,
		input openadc_regs_pkg::byte_t exp);
		if (got !== exp)
			report_error($sformatf("%s got %h expected %h", what, got, exp));
	endtask

	task automatic check_word(input string what, input openadc_regs_pkg::word_t got,
		input openadc_regs_pkg::word_t exp);
		if (got !== exp)
			report_error($sformatf("%s got %h expected %h", what, got, exp));
	endtask

	task automatic check_phase(input string what, input openadc_regs_pkg::phase_t got,
		input openadc_regs_pkg::phase_t exp);
		if (got !== exp)
			report_error($sformatf("%s got %h expected %h", what, got, exp));
	endtask

	task automatic check_trig(input string what, input openadc_regs_pkg::trig_ctrl_t got,
		input openadc_regs_pkg::trig_ctrl_t exp);
		if (got !== exp)
			report_error($sformatf("%s got %h expected %h", what, got, exp));
	endtask

	task automatic finish_test(input string name);
		$display("%-22s %s (%0d errors)", name, (test_errs == 0) ? "passed" : "FAILED",
			test_errs);
		err_count += test_errs;
		test_errs = 0;
		tests_run++;
	endtask

	// Host side of one byte toward the DUT
	task automatic send_byte(input openadc_regs_pkg::byte_t b);
		@(posedge ftdi_clk);
		host_in.rxf <= 1'b1;
		do
			@(negedge ftdi_clk);
		while (!host_out.rd);
		@(posedge ftdi_clk);
		host_in.rxf <= 1'b0;
		host_in.din <= b; // Valid the cycle after rd
		@(posedge ftdi_clk);
	endtask

	task automatic get_byte(output openadc_regs_pkg::byte_t b);
		do
			@(negedge ftdi_clk);
		while (!host_out.wr);
		b = host_out.dout;
		if (host_out.isout !== 1'b1)
			report_error("bus direction not out while sending");
		@(posedge ftdi_clk);
	endtask

	task automatic write_reg(input openadc_regs_pkg::reg_addr_t a,
		input openadc_regs_pkg::byte_t d);
		send_byte({2'b11, a});
		send_byte(d);
		repeat (3) @(posedge ftdi_clk);
		if (host_out.isout !== 1'b0)
			report_error("bus direction not in after a write");
	endtask

	task automatic read_reg(input openadc_regs_pkg::reg_addr_t a,
		output openadc_regs_pkg::byte_t d);
		send_byte({2'b10, a});
		get_byte(d);
	endtask

	task automatic test_reset_defaults();
		openadc_regs_pkg::trig_ctrl_t zero_trig;
		zero_trig = '0;
		@(negedge ftdi_clk);
		check_byte("gain after reset", gain, 8'h00);
		check_trig("trig after reset", trig, zero_trig);
		check_word("samples after reset", maxsamples_out, maxsamples_in);
		check_phase("phase after reset", phase_out, 9'h000);
		if (host_out.rd || host_out.wr || host_out.isout || fifo_rd_en || phase_ld || hilow ||
			adc_clk_src) begin
			$display("A control output is high after reset");
			test_errs++;
		end
		finish_test("reset defaults");
	endtask

	task automatic test_write_read();
		openadc_regs_pkg::byte_t d[10];
		openadc_regs_pkg::byte_t r;
		openadc_regs_pkg::reg_addr_t addrs[10];
		addrs = '{6'd0, 6'd4, 6'd16, 6'd17, 6'd18, 6'd19, 6'd26, 6'd27, 6'd28, 6'd29};
		foreach (d[i]) begin
			d[i] = 8'($urandom);
			write_reg(addrs[i], d[i]);
		end
		foreach (d[i]) begin
			read_reg(addrs[i], r);
			check_byte($sformatf("read back of address %0d", addrs[i]), r, d[i]);
		end
		exp_offset = {d[9], d[8], d[7], d[6]};
		check_byte("gain output", gain, d[0]);
		check_word("samples output", maxsamples_out, {d[5], d[4], d[3], d[2]});
		check_word("trigger offset", trig.offset, exp_offset);
		finish_test("write and read back");
	endtask

	task automatic test_settings();
		openadc_regs_pkg::trig_ctrl_t exp_trig;
		openadc_regs_pkg::byte_t r;
		openadc_regs_pkg::byte_t s;
		int ctrl_bits[5];
		ctrl_bits = '{1, 2, 3, 5, 6};
		foreach (ctrl_bits[i]) begin
			s = 8'(1 << ctrl_bits[i]); // One control bit at a time
			write_reg(6'd1, s);
			exp_trig.arm     = s[3];
			exp_trig.mode    = s[2];
			exp_trig.wait_en = s[5];
			exp_trig.offset  = exp_offset;
			check_trig($sformatf("trig from settings %h", s), trig, exp_trig);
			if (hilow !== s[1] || adc_clk_src !== s[6])
				report_error($sformatf("hilow or clock source wrong for settings %h", s));
		end
		write_reg(6'd1, 8'h7E);
		read_reg(6'd1, r);
		check_byte("settings read", r, 8'h7E);
		rst_count = 0;
		write_reg(6'd1, 8'h01);
		if (rst_count != 1)
			$display("Soft reset gave %0d reset cycles instead of one", rst_count);
		if (rst_count != 1)
			test_errs++;
		read_reg(6'd1, r);
		check_byte("settings after soft reset", r, 8'h00);
		check_word("samples after soft reset", maxsamples_out, maxsamples_in);
		check_byte("gain after soft reset", gain, 8'h00);
		exp_offset = '0;
		check_word("offset after soft reset", trig.offset, exp_offset);
		finish_test("settings and reset");
	endtask

	task automatic test_freq_snapshot();
		openadc_regs_pkg::word_t held;
		openadc_regs_pkg::word_t got;
		openadc_regs_pkg::byte_t r;
		status <= 8'($urandom);
		@(posedge ftdi_clk);
		read_reg(6'd2, r);
		check_byte("status read", r, status);
		held = extclk_freq;
		for (int i = 0; i < 4; i++) begin
			read_reg(6'(5 + i), r);
			got[8*i +: 8] = r;
			extclk_freq <= $urandom; // Snapshot must ignore this
			@(posedge ftdi_clk);
		end
		check_word("frequency snapshot", got, held);
		finish_test("frequency snapshot");
	endtask

	task automatic test_phase();
		openadc_regs_pkg::phase_t set_val;
		openadc_regs_pkg::phase_t res_val;
		openadc_regs_pkg::byte_t r;
		set_val = 9'($urandom);
		res_val = 9'($urandom);
		ld_count = 0;
		write_reg(6'd9, set_val[7:0]);
		write_reg(6'd10, {6'd0, 1'b1, set_val[8]});
		check_phase("phase output", phase_out, set_val);
		if (ld_count != 1)
			report_error($sformatf("%0d load pulses instead of one", ld_count));
		@(posedge ftdi_clk);
		phase_in   <= res_val;
		phase_done <= 1'b1;
		@(posedge ftdi_clk);
		phase_done <= 1'b0;
		read_reg(6'd9, r);
		check_byte("phase result low", r, res_val[7:0]);
		read_reg(6'd10, r);
		check_byte("phase result high", r, {6'd0, 1'b1, res_val[8]});
		write_reg(6'd10, 8'h02);
		read_reg(6'd10, r);
		check_byte("phase status after load", r, 8'h00);
		finish_test("phase adjust");
	endtask

	task automatic test_stream();
		openadc_regs_pkg::byte_t exp_q[$];
		openadc_regs_pkg::byte_t r;
		int n;
		int start;
		n = $urandom_range(0, 20);
		for (int i = 0; i < n; i++) begin
			exp_q.push_back(8'($urandom));
			fifo_q.push_back(exp_q[i]);
		end
		random_txe <= 1'b1;
		start = wr_count;
		send_byte(8'h83);
		get_byte(r);
		check_byte("sync byte", r, 8'hAC);
		for (int i = 0; i < n; i++) begin
			get_byte(r);
			check_byte($sformatf("stream byte %0d", i), r, exp_q[i]);
		end
		repeat (20) @(posedge ftdi_clk);
		random_txe <= 1'b0;
		if (wr_count - start != n + 1)
			report_error($sformatf("%0d bytes streamed for %0d samples", wr_count - start, n));
		if (fifo_q.size() != 0)
			report_error("sample FIFO not drained");
		finish_test($sformatf("sample stream N=%0d", n));
	endtask

	task automatic test_ignored();
		openadc_regs_pkg::byte_t r;
		openadc_regs_pkg::byte_t e;
		int start;
		e = 8'($urandom);
		write_reg(6'd4, e);
		start = wr_count;
		send_byte(8'h8C); // Unmapped address 12
		repeat (20) @(posedge ftdi_clk);
		send_byte(8'h04); // Bit 7 clear
		repeat (20) @(posedge ftdi_clk);
		if (wr_count != start)
			report_error("reply sent for an ignored command");
		read_reg(6'd4, r);
		check_byte("echo read", r, e);
		repeat (20) @(posedge ftdi_clk);
		if (wr_count - start != 1)
			report_error($sformatf("%0d replies to one echo read", wr_count - start));
		finish_test("ignored commands");
	endtask

	initial begin
		void'($urandom(32'hffd82781));
		cycles        = 0;
		wr_count      = 0;
		ld_count      = 0;
		rst_count     = 0;
		err_count     = 0;
		test_errs     = 0;
		tests_run     = 0;
		exp_offset    = '0;
		random_txe    = 1'b0;
		reset_i       = 1'b1;
		host_in       = '0;
		host_in.txe   = 1'b1;
		status        = 8'h5A;
		fifo_empty    = 1'b1;
		fifo_data     = '0;
		extclk_freq   = $urandom;
		phase_in      = '0;
		phase_done    = 1'b0;
		maxsamples_in = $urandom;
		repeat (4) @(posedge ftdi_clk);
		reset_i <= 1'b0;
		@(posedge ftdi_clk);

		test_reset_defaults();
		test_write_read();
		test_settings();
		test_freq_snapshot();
		test_phase();
		test_stream();
		test_ignored();

		$display("%0d tests run, %0d errors, %0d cycles", tests_run, err_count, cycles);
		if (err_count == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: hdl/usb_interface.sv
`timescale 1ns/1ps
`default_nettype none

// Host command interface of the scope front end
module usb_interface (
	input  logic                         ftdi_clk,
	input  logic                         reset_i,
	input  host_link_pkg::host_in_t      host_i,
	output host_link_pkg::host_out_t     host_o,
	input  openadc_regs_pkg::byte_t      status_i,
	input  logic                         fifo_empty_i,
	input  openadc_regs_pkg::byte_t      fifo_data_i,
	output logic                         fifo_rd_en_o,
	input  openadc_regs_pkg::word_t      extclk_frequency_i,
	input  openadc_regs_pkg::phase_t     phase_i,
	input  logic                         phase_done_i,
	input  openadc_regs_pkg::word_t      maxsamples_i,
	output logic                         reset_o,
	output logic                         hilow_o,
	output logic                         adc_clk_src_o,
	output logic                         phase_ld_o,
	output openadc_regs_pkg::byte_t      gain_o,
	output openadc_regs_pkg::trig_ctrl_t trig_o,
	output openadc_regs_pkg::word_t      maxsamples_o,
	output openadc_regs_pkg::phase_t     phase_o
);

	host_link_pkg::reg_req_t  req;
	host_link_pkg::reg_resp_t resp;

	// Runs from the internal reset so a soft reset also aborts it
	host_cmd_seq u_seq (
		.ftdi_clk     (ftdi_clk),
		.reset        (reset_o),
		.host_i       (host_i),
		.host_o       (host_o),
		.fifo_empty_i (fifo_empty_i),
		.fifo_data_i  (fifo_data_i),
		.fifo_rd_en_o (fifo_rd_en_o),
		.req_o        (req),
		.resp_i       (resp)
	);

	config_regs u_regs (
		.ftdi_clk           (ftdi_clk),
		.reset_i            (reset_i),
		.req_i              (req),
		.resp_o             (resp),
		.status_i           (status_i),
		.extclk_frequency_i (extclk_frequency_i),
		.phase_i            (phase_i),
		.phase_done_i       (phase_done_i),
		.maxsamples_i       (maxsamples_i),
		.reset_o            (reset_o),
		.hilow_o            (hilow_o),
		.adc_clk_src_o      (adc_clk_src_o),
		.gain_o             (gain_o),
		.trig_o             (trig_o),
		.maxsamples_o       (maxsamples_o),
		.phase_o            (phase_o),
		.phase_ld_o         (phase_ld_o)
	);

endmodule

`default_nettype wire

// File: hdl/config_regs.sv
`timescale 1ns/1ps
`default_nettype none

module config_regs (
	input  logic                         ftdi_clk,
	input  logic                         reset_i,
	input  host_link_pkg::reg_req_t      req_i,
	output host_link_pkg::reg_resp_t     resp_o,
	input  openadc_regs_pkg::byte_t      status_i,
	input  openadc_regs_pkg::word_t      extclk_frequency_i,
	input  openadc_regs_pkg::phase_t     phase_i,
	input  logic                         phase_done_i,
	input  openadc_regs_pkg::word_t      maxsamples_i,
	output logic                         reset_o,
	output logic                         hilow_o,
	output logic                         adc_clk_src_o,
	output openadc_regs_pkg::byte_t      gain_o,
	output openadc_regs_pkg::trig_ctrl_t trig_o,
	output openadc_regs_pkg::word_t      maxsamples_o,
	output openadc_regs_pkg::phase_t     phase_o,
	output logic                         phase_ld_o
);

	logic                        reset;
	logic                        reset_latched;
	openadc_regs_pkg::byte_t     gain_q;
	openadc_regs_pkg::byte_t     settings_q;
	openadc_regs_pkg::byte_t     echo_q;
	openadc_regs_pkg::word_t     samples_q;
	openadc_regs_pkg::word_t     offset_q;
	openadc_regs_pkg::word_t     freq_snap;
	logic                        freq_lock;
	logic                        freq_hold;
	openadc_regs_pkg::phase_t    phase_out_q;
	openadc_regs_pkg::phase_t    phase_in_q;
	logic                        phase_done_q;
	openadc_regs_pkg::reg_addr_t samp_rel;
	openadc_regs_pkg::reg_addr_t offs_rel;
	openadc_regs_pkg::reg_addr_t freq_rel;
	logic                        samp_sel;
	logic                        offs_sel;
	logic                        freq_sel;

	// Soft reset from settings bit 0 clears itself one cycle later
	assign reset   = reset_i | reset_latched;
	assign reset_o = reset;

	// Byte lanes of the 32-bit groups
	assign samp_rel = req_i.addr - openadc_regs_pkg::SAMPLES_ADDR;
	assign offs_rel = req_i.addr - openadc_regs_pkg::OFFSET_ADDR;
	assign freq_rel = req_i.addr - openadc_regs_pkg::EXTFREQ_ADDR;
	assign samp_sel = (samp_rel[5:2] == 4'd0);
	assign offs_sel = (offs_rel[5:2] == 4'd0);
	assign freq_sel = (freq_rel[5:2] == 4'd0);

	// Reads of frequency bytes 5 to 7 keep the snapshot frozen
	assign freq_hold = req_i.rd_en && freq_sel && (freq_rel[1:0] != 2'd3);

	assign gain_o         = gain_q;
	assign hilow_o        = settings_q[openadc_regs_pkg::SET_HILOW];
	assign adc_clk_src_o  = settings_q[openadc_regs_pkg::SET_CLK_SRC];
	assign trig_o.arm     = settings_q[openadc_regs_pkg::SET_ARM];
	assign trig_o.mode    = settings_q[openadc_regs_pkg::SET_TRIG_MODE];
	assign trig_o.wait_en = settings_q[openadc_regs_pkg::SET_WAIT];
	assign trig_o.offset  = offset_q;
	assign maxsamples_o   = samples_q;
	assign phase_o        = phase_out_q;

	always_ff @(posedge ftdi_clk or posedge reset_i) begin
		if (reset_i)
			reset_latched <= 1'b0;
		else
			reset_latched <= settings_q[openadc_regs_pkg::SET_RESET];
	end

	always_ff @(posedge ftdi_clk or posedge reset) begin
		if (reset) begin
			gain_q      <= '0;
			settings_q  <= '0;
			echo_q      <= '0;
			samples_q   <= maxsamples_i; // Largest capture by default
			offset_q    <= '0;
			phase_out_q <= '0;
		end else if (req_i.wr_en) begin
			case (req_i.addr)
				openadc_regs_pkg::GAIN_ADDR:     gain_q <= req_i.wdata;
				openadc_regs_pkg::SETTINGS_ADDR: settings_q <= req_i.wdata;
				openadc_regs_pkg::ECHO_ADDR:     echo_q <= req_i.wdata;
				openadc_regs_pkg::PHASE_LO_ADDR: phase_out_q[7:0] <= req_i.wdata;
				openadc_regs_pkg::PHASE_HI_ADDR:
					phase_out_q[8] <= req_i.wdata[openadc_regs_pkg::PH_MSB];
				default: ;
			endcase
			if (samp_sel)
				samples_q[{samp_rel[1:0], 3'b000} +: 8] <= req_i.wdata;
			if (offs_sel)
				offset_q[{offs_rel[1:0], 3'b000} +: 8] <= req_i.wdata;
		end
	end

	// One cycle load strobe to the phase shifter
	always_ff @(posedge ftdi_clk or posedge reset) begin
		if (reset)
			phase_ld_o <= 1'b0;
		else
			phase_ld_o <= req_i.wr_en && (req_i.addr == openadc_regs_pkg::PHASE_HI_ADDR) &&
				req_i.wdata[openadc_regs_pkg::PH_LOAD];
	end

	// Result of the last phase shift
	always_ff @(posedge ftdi_clk or posedge reset) begin
		if (reset) begin
			phase_in_q   <= '0;
			phase_done_q <= 1'b0;
		end else if (phase_ld_o) begin
			phase_in_q   <= '0; // New shift started
			phase_done_q <= 1'b0;
		end else if (phase_done_i) begin
			phase_in_q   <= phase_i;
			phase_done_q <= 1'b1;
		end
	end

	always_ff @(posedge ftdi_clk or posedge reset) begin
		if (reset)
			freq_lock <= 1'b0;
		else if (req_i.rd_en)
			freq_lock <= freq_hold; // Any other read releases it
	end

	always_ff @(posedge ftdi_clk) begin
		if (!freq_lock && !freq_hold)
			freq_snap <= extclk_frequency_i;
	end

	// Read byte for the addressed register
	always_comb begin
		resp_o.hit   = 1'b1;
		resp_o.rdata = '0;
		if (samp_sel) begin
			resp_o.rdata = samples_q[{samp_rel[1:0], 3'b000} +: 8];
		end else if (offs_sel) begin
			resp_o.rdata = offset_q[{offs_rel[1:0], 3'b000} +: 8];
		end else if (freq_sel) begin
			resp_o.rdata = freq_snap[{freq_rel[1:0], 3'b000} +: 8];
		end else begin
			case (req_i.addr)
				openadc_regs_pkg::GAIN_ADDR:     resp_o.rdata = gain_q;
				openadc_regs_pkg::SETTINGS_ADDR: resp_o.rdata = settings_q;
				openadc_regs_pkg::STATUS_ADDR:   resp_o.rdata = status_i;
				openadc_regs_pkg::ECHO_ADDR:     resp_o.rdata = echo_q;
				openadc_regs_pkg::PHASE_LO_ADDR: resp_o.rdata = phase_in_q[7:0];
				openadc_regs_pkg::PHASE_HI_ADDR: begin
					resp_o.rdata[openadc_regs_pkg::PH_MSB]  = phase_in_q[8];
					resp_o.rdata[openadc_regs_pkg::PH_DONE] = phase_done_q;
				end
				default: resp_o.hit = 1'b0;
			endcase
		end
	end

	// Load strobe is a single pulse, writes are several cycles apart
	a_ld_pulse: assert property (@(posedge ftdi_clk) disable iff (reset)
		phase_ld_o |=> !phase_ld_o);

endmodule

`default_nettype wire

// File: hdl/host_cmd_seq.sv
`timescale 1ns/1ps
`default_nettype none

module host_cmd_seq (
	input  logic                     ftdi_clk,
	input  logic                     reset,
	input  host_link_pkg::host_in_t  host_i,
	output host_link_pkg::host_out_t host_o,
	input  logic                     fifo_empty_i,
	input  openadc_regs_pkg::byte_t  fifo_data_i,
	output logic                     fifo_rd_en_o,
	output host_link_pkg::reg_req_t  req_o,
	input  host_link_pkg::reg_resp_t resp_i
);

	host_link_pkg::seq_state_t   state;
	openadc_regs_pkg::reg_addr_t addr_q;
	openadc_regs_pkg::byte_t     dout_q;
	logic                        rd_q;
	logic                        isout_q;
	logic                        is_adc;
	logic                        sending;

	// ADC data never reaches the register file
	assign is_adc = (addr_q == openadc_regs_pkg::ADCDATA_ADDR);

	assign sending = (state == host_link_pkg::RD_REPLY) ||
		(state == host_link_pkg::STREAM_SEND);

	// Host link side
	assign host_o.rd    = rd_q;
	assign host_o.wr    = sending && host_i.txe; // Only while host has room
	assign host_o.dout  = dout_q;
	assign host_o.isout = isout_q;

	// FIFO head is still valid during the fetch cycle
	assign fifo_rd_en_o = (state == host_link_pkg::STREAM_FETCH);

	// Register file side
	assign req_o.wr_en = (state == host_link_pkg::WR_DATA) && !is_adc;
	assign req_o.rd_en = (state == host_link_pkg::RD_LOOKUP) && !is_adc;
	assign req_o.addr  = addr_q;
	assign req_o.wdata = host_i.din;

	always_ff @(posedge ftdi_clk or posedge reset) begin
		if (reset) begin
			state   <= host_link_pkg::IDLE;
			rd_q    <= 1'b0;
			isout_q <= 1'b0;
		end else begin
			case (state)
				host_link_pkg::IDLE: begin
					if (rd_q) begin
						rd_q  <= 1'b0;
						state <= host_link_pkg::CMD;
					end else if (host_i.rxf) begin
						rd_q    <= 1'b1;
						isout_q <= 1'b0; // New command byte on its way
					end
				end

				host_link_pkg::CMD: begin
					if (!host_i.din[host_link_pkg::CMD_VALID_BIT]) begin
						isout_q <= 1'b0;
						state   <= host_link_pkg::IDLE; // Not a command, dropped
					end else if (host_i.din[host_link_pkg::CMD_WRITE_BIT]) begin
						isout_q <= 1'b0;
						state   <= host_link_pkg::WR_WAIT;
					end else begin
						isout_q <= 1'b1;
						state   <= host_link_pkg::RD_LOOKUP;
					end
				end

				// Fetch the data byte of a write
				host_link_pkg::WR_WAIT: begin
					if (rd_q) begin
						rd_q  <= 1'b0;
						state <= host_link_pkg::WR_DATA;
					end else if (host_i.rxf) begin
						rd_q <= 1'b1;
					end
				end

				host_link_pkg::WR_DATA: begin
					state <= host_link_pkg::IDLE;
				end

				host_link_pkg::RD_LOOKUP: begin
					if (is_adc)
						state <= host_link_pkg::STREAM_SEND;
					else if (resp_i.hit)
						state <= host_link_pkg::RD_REPLY;
					else
						state <= host_link_pkg::IDLE; // Unmapped, no reply
				end

				host_link_pkg::RD_REPLY: begin
					if (host_i.txe)
						state <= host_link_pkg::IDLE;
				end

				host_link_pkg::STREAM_SEND: begin
					if (host_i.txe) begin
						if (fifo_empty_i)
							state <= host_link_pkg::IDLE; // Stream done
						else
							state <= host_link_pkg::STREAM_FETCH;
					end
				end

				host_link_pkg::STREAM_FETCH: begin
					state <= host_link_pkg::STREAM_SEND;
				end

				default: begin
					state <= host_link_pkg::IDLE;
				end
			endcase
		end
	end

	// Address and outgoing byte
	always_ff @(posedge ftdi_clk) begin
		if (state == host_link_pkg::CMD)
			addr_q <= host_i.din[openadc_regs_pkg::ADDR_W-1:0];

		if (state == host_link_pkg::RD_LOOKUP)
			dout_q <= is_adc ? host_link_pkg::SYNC_BYTE : resp_i.rdata;
		else if (state == host_link_pkg::STREAM_FETCH)
			dout_q <= fifo_data_i;
	end

	// Half duplex link, one direction per cycle
	a_rd_wr_excl: assert property (@(posedge ftdi_clk) disable iff (reset)
		!(host_o.rd && host_o.wr));

	// Never pop an empty sample FIFO
	a_fifo_pop: assert property (@(posedge ftdi_clk) disable iff (reset)
		fifo_rd_en_o |-> !fifo_empty_i);

	a_wr_room: assert property (@(posedge ftdi_clk) disable iff (reset)
		host_o.wr |-> host_i.txe);

endmodule

`default_nettype wire

// File: hdl/host_link_pkg.sv
`default_nettype none

// Byte protocol of the host FIFO link
package host_link_pkg;

	// Command byte fields
	localparam int CMD_VALID_BIT = 7;
	localparam int CMD_WRITE_BIT = 6;

	// Leads every ADC data stream
	localparam openadc_regs_pkg::byte_t SYNC_BYTE = 8'hAC;

	typedef enum logic [2:0] {
		IDLE,
		CMD,
		WR_WAIT,
		WR_DATA,
		RD_LOOKUP,
		RD_REPLY,
		STREAM_SEND,
		STREAM_FETCH
	} seq_state_t;

	typedef struct packed {
		logic                    rxf;   // Byte waiting from host
		logic                    txe;   // Host can take a byte
		openadc_regs_pkg::byte_t din;
	} host_in_t;

	typedef struct packed {
		logic                    rd;
		logic                    wr;
		openadc_regs_pkg::byte_t dout;
		logic                    isout; // Bus direction for half duplex parts
	} host_out_t;

	// Register access from the sequencer
	typedef struct packed {
		logic                        wr_en;
		logic                        rd_en;
		openadc_regs_pkg::reg_addr_t addr;
		openadc_regs_pkg::byte_t     wdata;
	} reg_req_t;

	typedef struct packed {
		logic                    hit;   // Address is mapped
		openadc_regs_pkg::byte_t rdata;
	} reg_resp_t;

endpackage

`default_nettype wire

// File: hdl/openadc_regs_pkg.sv
`default_nettype none

// Register map and data types of the scope front end
package openadc_regs_pkg;

	// Data widths
	localparam int BYTE_W  = 8;
	localparam int WORD_W  = 32;
	localparam int ADDR_W  = 6;
	localparam int PHASE_W = 9;

	typedef logic [BYTE_W-1:0]  byte_t;
	typedef logic [WORD_W-1:0]  word_t;
	typedef logic [ADDR_W-1:0]  reg_addr_t;
	typedef logic [PHASE_W-1:0] phase_t;

	// Register addresses, multi-byte groups hold the LSB at the lowest address
	localparam reg_addr_t GAIN_ADDR     = 6'd0;
	localparam reg_addr_t SETTINGS_ADDR = 6'd1;
	localparam reg_addr_t STATUS_ADDR   = 6'd2;
	localparam reg_addr_t ADCDATA_ADDR  = 6'd3;
	localparam reg_addr_t ECHO_ADDR     = 6'd4;
	localparam reg_addr_t EXTFREQ_ADDR  = 6'd5;  // Up to 8
	localparam reg_addr_t PHASE_LO_ADDR = 6'd9;
	localparam reg_addr_t PHASE_HI_ADDR = 6'd10;
	localparam reg_addr_t SAMPLES_ADDR  = 6'd16; // Up to 19
	localparam reg_addr_t OFFSET_ADDR   = 6'd26; // Up to 29

	// Settings register bits
	localparam int SET_RESET     = 0;
	localparam int SET_HILOW     = 1;
	localparam int SET_TRIG_MODE = 2;
	localparam int SET_ARM       = 3;
	localparam int SET_WAIT      = 5;
	localparam int SET_CLK_SRC   = 6;

	// Phase MSB register bits
	localparam int PH_MSB  = 0;
	localparam int PH_LOAD = 1; // On write
	localparam int PH_DONE = 1; // On read

	// Controls for the trigger unit
	typedef struct packed {
		logic  arm;
		logic  mode;
		logic  wait_en; // Wait for trigger to go inactive before arming
		word_t offset;
	} trig_ctrl_t;

endpackage

`default_nettype wire
